// File: design/pe_periph_pkg.sv
`default_nettype none

package pe_periph_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [23:0] mem_addr_t;
    typedef logic [3:0]  strobe_t;
    typedef logic [7:0]  region_t;
    typedef logic [63:0] mtime_t;
    typedef logic [3:0]  reg_off_t;

    // Source of the read word in the cycle after a request
    typedef enum logic [1:0] {
        SEL_DMEM,
        SEL_RTC,
        SEL_PLIC
    } bus_sel_e;

    //////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////

    // Region byte is address bits 31 to 24
    localparam region_t REGION_DMEM = 8'd1;
    localparam region_t REGION_RTC  = 8'd2;
    localparam region_t REGION_PLIC = 8'd4;

    // Timer registers
    localparam reg_off_t RTC_MTIME_LO    = 4'd0;
    localparam reg_off_t RTC_MTIME_HI    = 4'd4;
    localparam reg_off_t RTC_MTIMECMP_LO = 4'd8;
    localparam reg_off_t RTC_MTIMECMP_HI = 4'd12;

    // Interrupt controller registers
    localparam reg_off_t PLIC_ENABLE  = 4'd0;
    localparam reg_off_t PLIC_PENDING = 4'd4;
    localparam reg_off_t PLIC_CLAIM   = 4'd8;

    // Id handed out by a successful claim
    localparam word_t PLIC_SOURCE_ID = 32'd1;

    // Interrupt vector positions
    localparam int unsigned IRQ_MTI_BIT = 7;
    localparam int unsigned IRQ_MEI_BIT = 11;

endpackage

`default_nettype wire

// File: design/pe_bus_decoder.sv
`default_nettype none

module pe_bus_decoder (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // Core request
    input  logic                     bus_en_i,
    input  pe_periph_pkg::bus_addr_t bus_addr_i,

    // Read words from the targets
    input  pe_periph_pkg::word_t     dmem_data_i,
    input  pe_periph_pkg::word_t     rtc_rdata_i,
    input  pe_periph_pkg::word_t     plic_rdata_i,

    // Target enables
    output logic                     dmem_en_o,
    output logic                     rtc_en_o,
    output logic                     plic_en_o,

    // Read word back to the core
    output pe_periph_pkg::word_t     bus_rdata_o
);

    import pe_periph_pkg::*;

    //////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////

    region_t  region;
    bus_sel_e sel_d;
    bus_sel_e sel_q;

    assign region = bus_addr_i[31:24];

    // One-hot by construction, unmapped regions raise nothing
    assign dmem_en_o = bus_en_i && (region == REGION_DMEM);
    assign rtc_en_o  = bus_en_i && (region == REGION_RTC);
    assign plic_en_o = bus_en_i && (region == REGION_PLIC);

    // Anything not a peripheral reads back the data memory
    always_comb begin
        if (rtc_en_o) begin
            sel_d = SEL_RTC;
        end else if (plic_en_o) begin
            sel_d = SEL_PLIC;
        end else begin
            sel_d = SEL_DMEM;
        end
    end

    //////////////////////////////////////////////////
    // Read return
    //////////////////////////////////////////////////

    // Target of the previous cycle's request
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sel_q <= SEL_DMEM;
        end else begin
            sel_q <= sel_d;
        end
    end

    always_comb begin
        case (sel_q)
            SEL_RTC: begin
                bus_rdata_o = rtc_rdata_i;
            end
            SEL_PLIC: begin
                bus_rdata_o = plic_rdata_i;
            end
            default: begin
                bus_rdata_o = dmem_data_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/pe_rtc.sv
`default_nettype none

module pe_rtc (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // Register access
    input  logic                    en_i,
    input  pe_periph_pkg::strobe_t  we_i,
    input  pe_periph_pkg::reg_off_t off_i,
    input  pe_periph_pkg::word_t    wdata_i,
    output pe_periph_pkg::word_t    rdata_o,

    // Timer state
    output pe_periph_pkg::mtime_t   mtime_o,
    output logic                    mti_o
);

    import pe_periph_pkg::*;

    mtime_t mtime_q;
    mtime_t mtimecmp_q;
    word_t  rdata_d;
    word_t  rdata_q;
    logic   rd_en;
    logic   cmp_lo_wr;
    logic   cmp_hi_wr;

    assign rd_en     = en_i && (we_i == '0);
    assign cmp_lo_wr = en_i && (off_i == RTC_MTIMECMP_LO);
    assign cmp_hi_wr = en_i && (off_i == RTC_MTIMECMP_HI);

    //////////////////////////////////////////////////
    // Timer and compare
    //////////////////////////////////////////////////

    // Free running, not writable from the bus
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + mtime_t'(1);
        end
    end

    // All ones keeps the interrupt off until software arms it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (cmp_lo_wr && we_i[i]) begin
                    mtimecmp_q[8*i +: 8] <= wdata_i[8*i +: 8];
                end
                if (cmp_hi_wr && we_i[i]) begin
                    mtimecmp_q[32 + 8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    assign mti_o   = (mtime_q >= mtimecmp_q);
    assign mtime_o = mtime_q;

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    always_comb begin
        case (off_i)
            RTC_MTIME_LO: begin
                rdata_d = mtime_q[31:0];
            end
            RTC_MTIME_HI: begin
                rdata_d = mtime_q[63:32];
            end
            RTC_MTIMECMP_LO: begin
                rdata_d = mtimecmp_q[31:0];
            end
            RTC_MTIMECMP_HI: begin
                rdata_d = mtimecmp_q[63:32];
            end
            default: begin
                rdata_d = '0;
            end
        endcase
    end

    // Captured at the request edge, the core sees it next cycle
    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rdata_d;
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/pe_plic.sv
`default_nettype none

module pe_plic (
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // Register access
    input  logic                    en_i,
    input  pe_periph_pkg::strobe_t  we_i,
    input  pe_periph_pkg::reg_off_t off_i,
    input  pe_periph_pkg::word_t    wdata_i,
    output pe_periph_pkg::word_t    rdata_o,

    // Interrupt source and request to the core
    input  logic                    irq_i,
    output logic                    mei_o
);

    import pe_periph_pkg::*;

    logic  enable_q;
    logic  pending_q;
    logic  in_service_q;
    logic  rd_en;
    logic  wr_en;
    logic  claim;
    logic  complete;
    word_t rdata_d;
    word_t rdata_q;

    assign rd_en = en_i && (we_i == '0);
    assign wr_en = en_i && (we_i != '0);

    // A claim only succeeds on an enabled pending source
    assign claim    = rd_en && (off_i == PLIC_CLAIM) && pending_q && enable_q;
    assign complete = wr_en && (off_i == PLIC_CLAIM) && (wdata_i == PLIC_SOURCE_ID);

    //////////////////////////////////////////////////
    // Gateway state
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            enable_q     <= 1'b0;
            pending_q    <= 1'b0;
            in_service_q <= 1'b0;
        end else begin
            if (wr_en && (off_i == PLIC_ENABLE) && we_i[0]) begin
                enable_q <= wdata_i[0];
            end

            // Claim wins over a new request in the same cycle
            if (claim) begin
                pending_q    <= 1'b0;
                in_service_q <= 1'b1;
            end else begin
                if (irq_i && !in_service_q) begin
                    pending_q <= 1'b1;
                end
                if (complete) begin
                    in_service_q <= 1'b0;
                end
            end
        end
    end

    assign mei_o = pending_q && enable_q && !in_service_q;

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    always_comb begin
        rdata_d = '0;
        case (off_i)
            PLIC_ENABLE: begin
                rdata_d[0] = enable_q;
            end
            PLIC_PENDING: begin
                rdata_d[0] = pending_q;
            end
            PLIC_CLAIM: begin
                if (pending_q && enable_q) begin
                    rdata_d = PLIC_SOURCE_ID;
                end
            end
            default: begin
                rdata_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rdata_d;
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/pe_periph_top.sv
`default_nettype none

module pe_periph_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // Core bus
    input  logic                     bus_en_i,
    input  pe_periph_pkg::strobe_t   bus_we_i,
    input  pe_periph_pkg::bus_addr_t bus_addr_i,
    input  pe_periph_pkg::word_t     bus_wdata_i,
    output pe_periph_pkg::word_t     bus_rdata_o,

    // External data memory
    output logic                     dmem_en_o,
    output pe_periph_pkg::strobe_t   dmem_we_o,
    output pe_periph_pkg::mem_addr_t dmem_addr_o,
    output pe_periph_pkg::word_t     dmem_data_o,
    input  pe_periph_pkg::word_t     dmem_data_i,

    // Interrupts and time
    input  logic                     ext_irq_i,
    output pe_periph_pkg::mtime_t    mtime_o,
    output pe_periph_pkg::word_t     irq_o
);

    import pe_periph_pkg::*;

    logic  rtc_en;
    logic  plic_en;
    word_t rtc_rdata;
    word_t plic_rdata;
    logic  mti;
    logic  mei;

    // Memory sees the request as is, only the enable is decoded
    assign dmem_we_o   = bus_we_i;
    assign dmem_addr_o = bus_addr_i[23:0];
    assign dmem_data_o = bus_wdata_i;

    //////////////////////////////////////////////////
    // Bus decode
    //////////////////////////////////////////////////

    pe_bus_decoder u_decoder (
        .clk_i        (clk_i      ),
        .rst_ni       (rst_ni     ),
        .bus_en_i     (bus_en_i   ),
        .bus_addr_i   (bus_addr_i ),
        .dmem_data_i  (dmem_data_i),
        .rtc_rdata_i  (rtc_rdata  ),
        .plic_rdata_i (plic_rdata ),
        .dmem_en_o    (dmem_en_o  ),
        .rtc_en_o     (rtc_en     ),
        .plic_en_o    (plic_en    ),
        .bus_rdata_o  (bus_rdata_o)
    );

    //////////////////////////////////////////////////
    // Peripherals
    //////////////////////////////////////////////////

    pe_rtc u_rtc (
        .clk_i   (clk_i           ),
        .rst_ni  (rst_ni          ),
        .en_i    (rtc_en          ),
        .we_i    (bus_we_i        ),
        .off_i   (bus_addr_i[3:0] ),
        .wdata_i (bus_wdata_i     ),
        .rdata_o (rtc_rdata       ),
        .mtime_o (mtime_o         ),
        .mti_o   (mti             )
    );

    pe_plic u_plic (
        .clk_i   (clk_i           ),
        .rst_ni  (rst_ni          ),
        .en_i    (plic_en         ),
        .we_i    (bus_we_i        ),
        .off_i   (bus_addr_i[3:0] ),
        .wdata_i (bus_wdata_i     ),
        .rdata_o (plic_rdata      ),
        .irq_i   (ext_irq_i       ),
        .mei_o   (mei             )
    );

    //////////////////////////////////////////////////
    // Interrupt vector
    //////////////////////////////////////////////////

    // Machine timer and machine external, rest unused
    always_comb begin
        irq_o              = '0;
        irq_o[IRQ_MTI_BIT] = mti;
        irq_o[IRQ_MEI_BIT] = mei;
    end

endmodule

`default_nettype wire

// File: sim/tb_pe_periph.sv
`default_nettype none

module tb_pe_periph;

    import pe_periph_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int DMEM_WORDS   = 8;
    localparam int UNMAPPED_RD  = 4;
    localparam int CMP_DELTA    = 50;
    localparam int WAIT_MAX     = 100;
    // Each bus access takes at most 3 cycles
    // Each wait is bounded by WAIT_MAX
    localparam int TEST_CYCLES  = RESET_CYCLES + 3 * (2 * DMEM_WORDS + UNMAPPED_RD + 20)
                                  + 3 * WAIT_MAX + 40;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

    logic      clk_i;
    logic      rst_ni;
    logic      bus_en_i;
    strobe_t   bus_we_i;
    bus_addr_t bus_addr_i;
    word_t     bus_wdata_i;
    word_t     bus_rdata_o;
    logic      dmem_en_o;
    strobe_t   dmem_we_o;
    mem_addr_t dmem_addr_o;
    word_t     dmem_data_o;
    word_t     dmem_data_i;
    logic      ext_irq_i;
    mtime_t    mtime_o;
    word_t     irq_o;

    integer seed = 32'h109dab41;

    pe_periph_top dut (
        .clk_i       (clk_i      ),
        .rst_ni      (rst_ni     ),
        .bus_en_i    (bus_en_i   ),
        .bus_we_i    (bus_we_i   ),
        .bus_addr_i  (bus_addr_i ),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .dmem_en_o   (dmem_en_o  ),
        .dmem_we_o   (dmem_we_o  ),
        .dmem_addr_o (dmem_addr_o),
        .dmem_data_o (dmem_data_o),
        .dmem_data_i (dmem_data_i),
        .ext_irq_i   (ext_irq_i  ),
        .mtime_o     (mtime_o    ),
        .irq_o       (irq_o      )
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic fail_value(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    task automatic fail_other(input string msg);
        $display("ERROR: %s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping on first error");
    endtask

    //////////////////////////////////////////////////
    // Data memory model and its reference copy
    //////////////////////////////////////////////////

    word_t mem [mem_addr_t];
    word_t ref_mem [mem_addr_t];

    // Unwritten words depend on every address bit
    function automatic word_t fill_word(input mem_addr_t a);
        return {a[7:0] ^ 8'h5a, a};
    endfunction

    always @(posedge clk_i) begin
        word_t w;
        if (dmem_en_o) begin
            w = mem.exists(dmem_addr_o) ? mem[dmem_addr_o] : fill_word(dmem_addr_o);
            if (dmem_we_o != '0) begin
                for (int i = 0; i < 4; i++) begin
                    if (dmem_we_o[i]) w[8*i +: 8] = dmem_data_o[8*i +: 8];
                end
                mem[dmem_addr_o] = w;
            end else begin
                dmem_data_i <= w;
            end
        end
    end

    //////////////////////////////////////////////////
    // Reference state and functions
    //////////////////////////////////////////////////

    mtime_t mtime_model;
    mtime_t cmp_model;
    logic   en_model;
    logic   pend_model;
    logic   insvc_model;

    function automatic word_t expected_read(input region_t rg, input reg_off_t off,
                                            input mem_addr_t a);
        word_t r;
        r = '0;
        if (rg == REGION_RTC) begin
            if (off == RTC_MTIME_LO) r = mtime_model[31:0];
            else if (off == RTC_MTIME_HI) r = mtime_model[63:32];
            else if (off == RTC_MTIMECMP_LO) r = cmp_model[31:0];
            else if (off == RTC_MTIMECMP_HI) r = cmp_model[63:32];
        end else if (rg == REGION_PLIC) begin
            if (off == PLIC_ENABLE) r[0] = en_model;
            else if (off == PLIC_PENDING) r[0] = pend_model;
            else if (off == PLIC_CLAIM) r = expected_claim();
        end else begin
            r = ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
        end
        return r;
    endfunction

    function automatic logic expected_mti();
        return mtime_model >= cmp_model;
    endfunction

    function automatic word_t expected_claim();
        return (pend_model && en_model) ? 32'd1 : 32'd0;
    endfunction

    //////////////////////////////////////////////////
    // Model update and comparison at the falling edge
    //////////////////////////////////////////////////

    logic  chk_valid;
    logic  chk_unmapped;
    word_t chk_data;

    always @(negedge clk_i) begin
        region_t   rg;
        reg_off_t  off;
        logic      rd;
        logic      wr;
        logic      claim;
        word_t     w;
        rg  = bus_addr_i[31:24];
        off = bus_addr_i[3:0];
        rd  = bus_en_i && (bus_we_i == '0);
        wr  = bus_en_i && (bus_we_i != '0);
        if (!rst_ni) begin
            mtime_model = '0;
            cmp_model   = '1;
            en_model    = 1'b0;
            pend_model  = 1'b0;
            insvc_model = 1'b0;
            chk_valid   = 1'b0;
        end else begin
            assert (mtime_o == mtime_model) else fail_value("mtime_o off its count");
            assert (irq_o[IRQ_MTI_BIT] == expected_mti()) else fail_value("timer irq bit wrong");
            assert (irq_o[IRQ_MEI_BIT] == (pend_model && en_model && !insvc_model))
                else fail_value("external irq bit wrong");
            assert ((irq_o & ~((32'd1 << IRQ_MTI_BIT) | (32'd1 << IRQ_MEI_BIT))) == '0)
                else fail_value("unused irq bits set");
            if (chk_valid) begin
                assert (bus_rdata_o == (chk_unmapped ? dmem_data_i : chk_data))
                    else fail_value($sformatf("read data %h, expected %h", bus_rdata_o,
                                              chk_unmapped ? dmem_data_i : chk_data));
            end
            // Memory port follows the request of this cycle
            if (bus_en_i && rg == REGION_DMEM) begin
                assert (dmem_en_o && dmem_addr_o == bus_addr_i[23:0] && dmem_we_o == bus_we_i
                        && dmem_data_o == bus_wdata_i) else fail_value("dmem port mismatch");
            end else begin
                assert (!dmem_en_o) else fail_value("dmem_en_o high outside data region");
            end
            chk_valid    = rd;
            chk_unmapped = rg != REGION_DMEM && rg != REGION_RTC && rg != REGION_PLIC;
            chk_data     = expected_read(rg, off, bus_addr_i[23:0]);

            // State as it will be after the next rising edge
            claim = rd && rg == REGION_PLIC && off == PLIC_CLAIM && pend_model && en_model;
            if (wr && rg == REGION_DMEM) begin
                w = ref_mem.exists(bus_addr_i[23:0]) ? ref_mem[bus_addr_i[23:0]]
                                                      : fill_word(bus_addr_i[23:0]);
                for (int i = 0; i < 4; i++) begin
                    if (bus_we_i[i]) w[8*i +: 8] = bus_wdata_i[8*i +: 8];
                end
                ref_mem[bus_addr_i[23:0]] = w;
            end
            if (wr && rg == REGION_RTC && (off == RTC_MTIMECMP_LO || off == RTC_MTIMECMP_HI)) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus_we_i[i]) begin
                        cmp_model[(off == RTC_MTIMECMP_HI ? 32 : 0) + 8*i +: 8]
                            = bus_wdata_i[8*i +: 8];
                    end
                end
            end
            if (wr && rg == REGION_PLIC && off == PLIC_ENABLE && bus_we_i[0]) begin
                en_model = bus_wdata_i[0];
            end
            if (claim) begin
                pend_model  = 1'b0;
                insvc_model = 1'b1;
            end else begin
                if (ext_irq_i && !insvc_model) pend_model = 1'b1;
                if (wr && rg == REGION_PLIC && off == PLIC_CLAIM && bus_wdata_i == 32'd1) begin
                    insvc_model = 1'b0;
                end
            end
            mtime_model = mtime_model + 64'd1;
        end
    end

    //////////////////////////////////////////////////
    // Bus access tasks
    //////////////////////////////////////////////////

    task automatic bus_write(input bus_addr_t a, input strobe_t we, input word_t d);
        @(posedge clk_i);
        bus_en_i    <= 1'b1;
        bus_we_i    <= we;
        bus_addr_i  <= a;
        bus_wdata_i <= d;
        @(posedge clk_i);
        bus_en_i    <= 1'b0;
        bus_we_i    <= '0;
    endtask

    task automatic bus_read(input bus_addr_t a, output word_t d, output mtime_t mt);
        @(posedge clk_i);
        bus_en_i   <= 1'b1;
        bus_we_i   <= '0;
        bus_addr_i <= a;
        @(negedge clk_i);
        mt = mtime_o;
        @(posedge clk_i);
        bus_en_i <= 1'b0;
        @(negedge clk_i);
        d = bus_rdata_o;
    endtask

    task automatic wait_irq(input int bit_pos, input logic level);
        int n;
        n = 0;
        while (irq_o[bit_pos] !== level) begin
            @(negedge clk_i);
            n++;
            if (n > WAIT_MAX) fail_other($sformatf("irq bit %0d never reached %b", bit_pos, level));
        end
    endtask

    function automatic bus_addr_t reg_addr(input region_t rg, input reg_off_t off);
        return {rg, 20'h0, off};
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        bus_addr_t addrs [DMEM_WORDS];
        word_t     d;
        word_t     d2;
        mtime_t    mt;
        mtime_t    mt2;
        mtime_t    cmp;
        strobe_t   we;
        rst_ni      = 1'b0;
        bus_en_i    = 1'b0;
        bus_we_i    = '0;
        bus_addr_i  = '0;
        bus_wdata_i = '0;
        ext_irq_i   = 1'b0;
        dmem_data_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        assert (irq_o == '0) else fail_value("irq_o not clear after reset");

        // Random data memory words read back
        for (int i = 0; i < DMEM_WORDS; i++) begin
            addrs[i] = {REGION_DMEM, 24'($random(seed)) & 24'hfffffc};
            we = 4'($random(seed));
            bus_write(addrs[i], (we == '0) ? 4'hf : we, $random(seed));
        end
        for (int i = 0; i < DMEM_WORDS; i++) bus_read(addrs[i], d, mt);
        for (int i = 0; i < UNMAPPED_RD; i++) begin
            bus_read({8'h80 | 8'(i), 24'($random(seed))}, d, mt);
        end

        // Timer counting
        bus_read(reg_addr(REGION_RTC, RTC_MTIME_LO), d, mt);
        assert (d == mt[31:0]) else fail_value("mtime read differs from mtime_o");
        bus_read(reg_addr(REGION_RTC, RTC_MTIME_LO), d2, mt2);
        assert (d2 == mt2[31:0]) else fail_value("mtime read differs from mtime_o");
        assert (d2 > d) else fail_value("mtime not increasing");

        // Timer compare
        bus_read(reg_addr(REGION_RTC, RTC_MTIME_LO), d, mt);
        cmp = mt + 64'(CMP_DELTA);
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_HI), 4'hf, cmp[63:32]);
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_LO), 4'hf, cmp[31:0]);
        @(negedge clk_i);
        assert (irq_o[IRQ_MTI_BIT] == 1'b0) else fail_value("timer irq early");
        wait_irq(IRQ_MTI_BIT, 1'b1);
        assert (mtime_o >= cmp) else fail_value("timer irq before compare value");

        // Only the top byte is strobed and it keeps its value
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_LO), 4'b1000, {cmp[31:24], ~cmp[23:0]});
        bus_read(reg_addr(REGION_RTC, RTC_MTIMECMP_LO), d, mt);
        assert (d == cmp[31:0]) else fail_value("masked compare bytes changed");
        bus_read(reg_addr(REGION_RTC, RTC_MTIMECMP_HI), d, mt);
        assert (d == cmp[63:32]) else fail_value("compare high word wrong");
        assert (irq_o[IRQ_MTI_BIT] == 1'b1) else fail_value("timer irq lost after partial write");
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_LO), 4'hf, 32'hffff_ffff);
        wait_irq(IRQ_MTI_BIT, 1'b0);
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_HI), 4'hf, 32'hffff_ffff);

        // Enable and claim
        ext_irq_i <= 1'b1;
        repeat (3) @(negedge clk_i);
        assert (irq_o[IRQ_MEI_BIT] == 1'b0) else fail_value("external irq while disabled");
        bus_read(reg_addr(REGION_PLIC, PLIC_CLAIM), d, mt);
        assert (d == 32'd0) else fail_value("claim succeeded while disabled");
        bus_write(reg_addr(REGION_PLIC, PLIC_ENABLE), 4'hf, 32'd1);
        wait_irq(IRQ_MEI_BIT, 1'b1);
        bus_read(reg_addr(REGION_PLIC, PLIC_CLAIM), d, mt);
        assert (d == 32'd1) else fail_value("claim did not return the source id");
        assert (irq_o[IRQ_MEI_BIT] == 1'b0) else fail_value("external irq after claim");

        // Complete with the source still high and then with it dropped
        repeat (5) @(negedge clk_i);
        assert (irq_o[IRQ_MEI_BIT] == 1'b0) else fail_value("external irq while in service");
        bus_write(reg_addr(REGION_PLIC, PLIC_CLAIM), 4'hf, 32'd1);
        wait_irq(IRQ_MEI_BIT, 1'b1);
        bus_read(reg_addr(REGION_PLIC, PLIC_CLAIM), d, mt);
        assert (d == 32'd1) else fail_value("second claim failed");
        @(posedge clk_i);
        ext_irq_i <= 1'b0;
        repeat (2) @(negedge clk_i);
        bus_write(reg_addr(REGION_PLIC, PLIC_CLAIM), 4'hf, 32'd1);
        repeat (5) @(negedge clk_i);
        assert (irq_o[IRQ_MEI_BIT] == 1'b0) else fail_value("external irq with source low");
        bus_read(reg_addr(REGION_PLIC, PLIC_PENDING), d, mt);
        assert (d == 32'd0) else fail_value("pending set with source low");

        // Let the comparison process finish the last read
        @(posedge clk_i);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_other("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// File: compile.f
design/pe_periph_pkg.sv
design/pe_bus_decoder.sv
design/pe_rtc.sv
design/pe_plic.sv
design/pe_periph_top.sv
sim/tb_pe_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_pe_periph -f compile.f -o tb_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

! grep -q "TEST RESULT: FAIL" sim.log && grep -q "TEST RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
